// ==== hdl/cpu_isa_pkg.sv ====
/*
 * Instruction-set definitions for the RV64 subset
 * Word widths, opcodes, function codes, instruction and write structs
 */
`default_nettype none

package cpu_isa_pkg;

   // ========================================================================
   // Widths
   // ========================================================================
   // Register width
   localparam int xlen = 64;
   // Instruction width
   localparam int ilen = 32;
   // Architectural registers x0 to x31
   localparam int reg_count = 32;

   // ========================================================================
   // Opcodes and function codes
   // ========================================================================
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_op_imm = 7'b0010011;
   localparam logic [6:0] op_op     = 7'b0110011;
   localparam logic [6:0] op_store  = 7'b0100011;

   // Selects within op_op_imm, op_op and op_store
   localparam logic [2:0] funct3_addi = 3'b000;
   localparam logic [2:0] funct3_add  = 3'b000;
   localparam logic [2:0] funct3_sb   = 3'b000;

   // R-type layout, the other formats reuse these bit positions
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instr_fields_t;

   // Register write request, addr zero is dropped by the register file
   typedef struct packed {
      logic                         en;
      logic [$clog2(reg_count)-1:0] addr;
      logic [xlen-1:0]              data;
   } reg_write_t;

endpackage

`default_nettype wire

// ==== hdl/board_io_pkg.sv ====
/*
 * Board-side definitions
 * Memory depth, loader, console and LED view structs
 */
`default_nettype none

package board_io_pkg;

   // Instruction memory depth in words
   localparam int mem_words = 3000;
   // Word index width, enough for mem_words
   localparam int mem_addr_bits = 12;

   // Loader input, data is in image byte order
   typedef struct packed {
      logic                     en;
      logic [mem_addr_bits-1:0] addr;
      logic [31:0]              data;
   } load_t;

   // Console output, one character per write pulse
   typedef struct packed {
      logic       write;
      logic [7:0] data;
   } console_t;

   // Status LEDs
   typedef struct packed {
      logic [7:0] green;
      logic [7:0] red;
      logic       heartbeat;
   } led_view_t;

endpackage

`default_nettype wire

// ==== hdl/instr_fetch.sv ====
/*
 * Fetch stage with program counter, instruction memory and loader write
 * Fetched words are byte-swapped into the instruction register
 */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
   import cpu_isa_pkg::*;
   import board_io_pkg::*;
(
   input  wire           clock_1hz,
   input  wire           KEY0,
   input  load_t         load,
   output instr_fields_t ir
);

   // Byte address, two low bits always zero
   logic [mem_addr_bits+1:0] pc;
   logic [ilen-1:0]          mem [mem_words];
   logic [ilen-1:0]          mem_word;
   logic [ilen-1:0]          swapped;

   // ========================================================================
   // Instruction memory
   // ========================================================================
   // Loader port is the only writer
   always_ff @(posedge clock_1hz) begin
      if (load.en) begin
         mem[load.addr] <= load.data;
      end
   end

   // Word at the current pc
   assign mem_word = mem[pc[mem_addr_bits+1:2]];

   // Image is stored big-endian, reverse the four bytes
   assign swapped = {mem_word[7:0], mem_word[15:8], mem_word[23:16], mem_word[31:24]};

   // ========================================================================
   // PC and instruction register
   // ========================================================================
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         pc <= '0;
         ir <= '0;
      end else if (load.en) begin
         // Hold at address 0, an all-zero ir decodes as nothing
         pc <= '0;
         ir <= '0;
      end else begin
         pc <= pc + 4;
         ir <= instr_fields_t'(swapped);
      end
   end

   // PC must stay aligned and inside the loaded image
   pc_in_range_a : assert property (
      @(posedge clock_1hz) disable iff (!KEY0)
      (pc[1:0] == 2'b00) && (pc < mem_words * 4)
   );

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
/*
 * Register file of 32 x 64 bits with x0 fixed at zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file
   import cpu_isa_pkg::*;
(
   input  wire              clock_1hz,
   input  wire              KEY0,
   input  wire  [4:0]       rs1_addr,
   input  wire  [4:0]       rs2_addr,
   input  reg_write_t       reg_write,
   output logic [xlen-1:0]  rs1_data,
   output logic [xlen-1:0]  rs2_data,
   output logic [xlen-1:0]  x31
);

   logic [xlen-1:0] regs [reg_count];

   // Synchronous write port
   // Writes to x0 are ignored so regs[0] keeps its reset value
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_write.en && (reg_write.addr != '0)) begin
         regs[reg_write.addr] <= reg_write.data;
      end
   end

   // Asynchronous reads so a write is seen right after its edge
   assign rs1_data = regs[rs1_addr];
   assign rs2_data = regs[rs2_addr];

   // Continuous view of x31 for the LEDs
   assign x31 = regs[reg_count-1];

   // Address 0 reads as zero on both ports
   x0_reads_zero_a : assert property (
      @(posedge clock_1hz) disable iff (!KEY0)
      ((rs1_addr != '0) || (rs1_data == '0)) &&
      ((rs2_addr != '0) || (rs2_data == '0))
   );

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
/*
 * Execute stage, decodes LUI, ADDI, ADD and SB from the instruction register
 * Drives the register write request and the console pulse
 */
`timescale 1ns/1ps
`default_nettype none

module execute_unit
   import cpu_isa_pkg::*;
   import board_io_pkg::*;
(
   input  wire             clock_1hz,
   input  wire             KEY0,
   input  instr_fields_t   ir,
   input  wire [xlen-1:0]  rs1_data,
   input  wire [xlen-1:0]  rs2_data,
   output reg_write_t      reg_write,
   output console_t        console
);

   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_u;
   logic            is_lui;
   logic            is_addi;
   logic            is_add;
   logic            is_sb;

   // ========================================================================
   // Decode
   // ========================================================================
   assign is_lui  = (ir.opcode == op_lui);
   assign is_addi = (ir.opcode == op_op_imm) && (ir.funct3 == funct3_addi);
   // funct7 must be zero, otherwise it would be SUB
   assign is_add  = (ir.opcode == op_op) && (ir.funct3 == funct3_add) &&
                    (ir.funct7 == 7'b0000000);
   assign is_sb   = (ir.opcode == op_store) && (ir.funct3 == funct3_sb);

   // ========================================================================
   // Immediates
   // ========================================================================
   // I-type, ir[31:20] sign-extended
   assign imm_i = {{52{ir.funct7[6]}}, ir.funct7, ir.rs2};

   // U-type, upper 20 bits with low 12 cleared, then sign-extended from bit 31
   assign imm_u = {{32{ir.funct7[6]}}, ir.funct7, ir.rs2, ir.rs1, ir.funct3, 12'h000};

   // ========================================================================
   // Register write
   // ========================================================================
   // Lands on the edge that brings the next instruction into ir
   always_comb begin
      reg_write.en   = 1'b0;
      reg_write.addr = ir.rd;
      reg_write.data = '0;
      if (is_lui) begin
         reg_write.en   = 1'b1;
         reg_write.data = imm_u;
      end else if (is_addi) begin
         reg_write.en   = 1'b1;
         reg_write.data = rs1_data + imm_i;
      end else if (is_add) begin
         reg_write.en   = 1'b1;
         reg_write.data = rs1_data + rs2_data;
      end
   end

   // ========================================================================
   // Console
   // ========================================================================
   // One-cycle pulse per store-byte, data held until the next store
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         console.write <= 1'b0;
         console.data  <= 8'h00;
      end else begin
         console.write <= is_sb;
         if (is_sb) begin
            console.data <= rs2_data[7:0];
         end
      end
   end

   // Console is a strobe, stores are never issued back to back
   console_pulse_a : assert property (
      @(posedge clock_1hz) disable iff (!KEY0)
      console.write |=> !console.write
   );

endmodule

`default_nettype wire

// ==== hdl/cpu_on_board.sv ====
/*
 * Board top connecting fetch, register file and execute
 * Heartbeat flop and LED view
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board
   import cpu_isa_pkg::*;
   import board_io_pkg::*;
(
   input  wire       clock_1hz,
   input  wire       KEY0,
   input  load_t     load,
   output console_t  console,
   output led_view_t leds
);

   instr_fields_t   ir;
   reg_write_t      reg_write;
   logic [xlen-1:0] rs1_data;
   logic [xlen-1:0] rs2_data;
   logic [xlen-1:0] x31;
   logic            heartbeat;

   // ========================================================================
   // Core
   // ========================================================================
   instr_fetch u_fetch (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .load      (load),
      .ir        (ir)
   );

   // Register addresses come straight from ir
   reg_file u_regs (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .rs1_addr  (ir.rs1),
      .rs2_addr  (ir.rs2),
      .reg_write (reg_write),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .x31       (x31)
   );

   execute_unit u_exec (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .ir        (ir),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .reg_write (reg_write),
      .console   (console)
   );

   // ========================================================================
   // Status LEDs
   // ========================================================================
   // Heartbeat pauses while the loader is writing
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         heartbeat <= 1'b0;
      end else if (!load.en) begin
         heartbeat <= ~heartbeat;
      end
   end

   // Low byte of the instruction register
   assign leds.green     = ir[7:0];
   assign leds.red       = x31[19:12];
   assign leds.heartbeat = heartbeat;

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock source for clock_1hz, 40 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clock_1hz
);

   // Half of the 40 ns period
   localparam int half_period = 20;

   initial begin
      clock_1hz = 1'b0;
      forever begin
         #(half_period) clock_1hz = ~clock_1hz;
      end
   end

endmodule

`default_nettype wire

// ==== dv/cpu_checker.sv ====
/*
 * Testbench checker with a reference model fed from the program table
 * Compares console, LEDs and heartbeat on every falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker
   import cpu_isa_pkg::*;
   import board_io_pkg::*;
(
   input wire       clock_1hz,
   input wire       KEY0,
   input load_t     load,
   input console_t  console,
   input led_view_t leds
);

   int              error_count = 0;
   int              pulse_count = 0;
   logic            started = 1'b0;
   // Table index held in ir, -1 for a cleared ir, -2 past the table
   int              ir_idx = -1;
   int              pc_idx = 0;
   logic [xlen-1:0] model_regs [reg_count];
   logic            exp_write = 1'b0;
   logic [7:0]      exp_data = 8'h00;
   logic            exp_heartbeat = 1'b0;

   // x0 never changes
   task automatic write_reg(input logic [4:0] rd, input logic [xlen-1:0] value);
      if (rd != 5'd0) begin
         model_regs[rd] = value;
      end
   endtask

   // Effect of one table entry, by instruction semantics
   task automatic execute_entry(input int idx);
      logic [6:0] opcode;
      opcode = cpu_tb.prog[idx].instr[6:0];
      if (opcode == op_lui) begin
         write_reg(cpu_tb.prog[idx].rd, cpu_tb.prog[idx].imm);
      end else if (opcode == op_op_imm) begin
         write_reg(cpu_tb.prog[idx].rd,
                   model_regs[cpu_tb.prog[idx].rs1] + cpu_tb.prog[idx].imm);
      end else if (opcode == op_op) begin
         write_reg(cpu_tb.prog[idx].rd,
                   model_regs[cpu_tb.prog[idx].rs1] + model_regs[cpu_tb.prog[idx].rs2]);
      end else if (opcode == op_store) begin
         exp_write = 1'b1;
         exp_data  = cpu_tb.prog[idx].exp_byte;
      end
   endtask

   task automatic compare(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("ERR t=%0t %s expected %02h actual %02h", $time, name, expected, actual);
      end
   endtask

   // ========================================================================
   // Model, advanced on the rising edge
   // ========================================================================
   always @(posedge clock_1hz) begin
      started = 1'b1;
      if (!KEY0) begin
         ir_idx        = -1;
         pc_idx        = 0;
         exp_write     = 1'b0;
         exp_data      = 8'h00;
         exp_heartbeat = 1'b0;
         for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
         end
      end else begin
         // Instruction in ir retires on this edge
         exp_write = 1'b0;
         if (ir_idx >= 0) begin
            execute_entry(ir_idx);
         end
         // Loader holds fetch at word 0 with a cleared ir
         if (load.en) begin
            ir_idx = -1;
            pc_idx = 0;
         end else begin
            ir_idx = (pc_idx < cpu_tb.table_len) ? pc_idx : -2;
            pc_idx++;
            exp_heartbeat = ~exp_heartbeat;
         end
      end
   end

   // ========================================================================
   // Compare, outputs are stable between rising edges
   // ========================================================================
   always @(negedge clock_1hz) begin
      if (started) begin
         if (console.write === 1'b1) begin
            pulse_count++;
         end
         compare("console.write", 8'(exp_write), 8'(console.write));
         if (exp_write) begin
            compare("console.data", exp_data, console.data);
         end
         if (ir_idx >= 0) begin
            compare("leds.green", cpu_tb.prog[ir_idx].instr[7:0], leds.green);
         end else if (ir_idx == -1) begin
            compare("leds.green", 8'h00, leds.green);
         end
         compare("leds.red", model_regs[31][19:12], leds.red);
         compare("leds.heartbeat", 8'(exp_heartbeat), 8'(leds.heartbeat));
      end
   end

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
/*
 * Test top with program table, loader sequence, reset and watchdog
 * Runs the program twice, the second load restarts fetch mid-run
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
   import cpu_isa_pkg::*;
   import board_io_pkg::*;
();

   localparam int prog_len    = 16;
   localparam int clk_period  = 40;
   // Reset, two passes of load plus run, and some slack
   localparam int watchdog_ns = (8 + 2 * prog_len * 2 + 20) * clk_period;

   // One table entry, operands kept beside the encoded word
   typedef struct packed {
      logic [31:0]     instr;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [xlen-1:0] imm;
      logic            has_byte;
      logic [7:0]      exp_byte;
   } entry_t;

   entry_t    prog [prog_len];
   int        table_len;
   int        fail_count;
   int        expected_pulses;
   logic      clock_1hz;
   logic      KEY0;
   load_t     load;
   console_t  console;
   led_view_t leds;

   tb_clock_gen clk0 (.clock_1hz(clock_1hz));

   cpu_on_board dut0 (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .load      (load),
      .console   (console),
      .leds      (leds)
   );

   cpu_checker checker0 (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .load      (load),
      .console   (console),
      .leds      (leds)
   );

   // ========================================================================
   // Encoders
   // ========================================================================
   function automatic entry_t encode_lui(input logic [4:0] rd, input logic [19:0] imm20);
      entry_t e;
      e       = '0;
      e.instr = {imm20, rd, op_lui};
      e.rd    = rd;
      // U immediate, sign taken from bit 31
      e.imm   = {{32{imm20[19]}}, imm20, 12'h000};
      return e;
   endfunction

   function automatic entry_t encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm12);
      entry_t e;
      e       = '0;
      e.instr = {imm12, rs1, funct3_addi, rd, op_op_imm};
      e.rd    = rd;
      e.rs1   = rs1;
      e.imm   = {{52{imm12[11]}}, imm12};
      return e;
   endfunction

   function automatic entry_t encode_add(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      entry_t e;
      e       = '0;
      e.instr = {7'b0000000, rs2, rs1, funct3_add, rd, op_op};
      e.rd    = rd;
      e.rs1   = rs1;
      e.rs2   = rs2;
      return e;
   endfunction

   // Store-byte to offset 0 from x0
   function automatic entry_t encode_sb(input logic [4:0] rs2, input logic [7:0] exp_byte);
      entry_t e;
      e          = '0;
      e.instr    = {7'b0000000, rs2, 5'd0, funct3_sb, 5'd0, op_store};
      e.rs2      = rs2;
      e.has_byte = 1'b1;
      e.exp_byte = exp_byte;
      return e;
   endfunction

   // Memory image keeps the bytes in reverse order
   function automatic logic [31:0] swap_bytes(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   task automatic build_program();
      logic [31:0] r;
      // "H" from x5, "A" from x6
      prog[0]  = encode_lui(5'd5, 20'h12345);
      prog[1]  = encode_addi(5'd5, 5'd5, 12'h048);
      prog[2]  = encode_sb(5'd5, 8'h48);
      prog[3]  = encode_lui(5'd6, 20'hABCDE);
      prog[4]  = encode_addi(5'd6, 5'd6, 12'h041);
      prog[5]  = encode_sb(5'd6, 8'h41);
      // x31 on the red LEDs, bit 31 set for sign extension
      prog[6]  = encode_lui(5'd31, 20'h80F5A);
      prog[7]  = encode_add(5'd31, 5'd31, 5'd5);
      prog[8]  = encode_addi(5'd31, 5'd31, 12'h800);
      // Write to x0 is dropped, its store sends zero
      prog[9]  = encode_addi(5'd0, 5'd5, 12'h7FF);
      prog[10] = encode_sb(5'd0, 8'h00);
      for (int i = 11; i < prog_len - 1; i++) begin
         r       = $urandom;
         prog[i] = encode_addi(5'd31, 5'd31, r[11:0]);
      end
      // Trailing no-op
      prog[prog_len-1] = encode_addi(5'd0, 5'd0, 12'h000);
   endtask

   // Called on a falling edge, one word per cycle
   task automatic load_program();
      for (int i = 0; i < prog_len; i++) begin
         load.en   = 1'b1;
         load.addr = i[mem_addr_bits-1:0];
         load.data = swap_bytes(prog[i].instr);
         @(negedge clock_1hz);
      end
      load = '0;
   endtask

   // ========================================================================
   // Run sequence
   // ========================================================================
   initial begin
      KEY0       = 1'b0;
      load       = '0;
      fail_count = 0;
      table_len  = prog_len;
      void'($urandom(52));
      build_program();
      expected_pulses = 0;
      for (int i = 0; i < prog_len; i++) begin
         if (prog[i].has_byte) begin
            expected_pulses += 2;
         end
      end
      repeat (8) @(negedge clock_1hz);
      KEY0 = 1'b1;
      load_program();
      repeat (prog_len) @(posedge clock_1hz);
      @(negedge clock_1hz);
      // Reload restarts fetch at word 0
      load_program();
      repeat (prog_len) @(posedge clock_1hz);
      @(negedge clock_1hz);
      @(posedge clock_1hz);
      if (checker0.pulse_count != expected_pulses) begin
         $display("Console sent %0d characters, the program sends %0d",
                  checker0.pulse_count, expected_pulses);
         fail_count++;
      end
      $display("Errors: value %0d, other %0d", checker0.error_count, fail_count);
      if (checker0.error_count == 0 && fail_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(watchdog_ns);
      $display("Run did not finish within %0d ns", watchdog_ns);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/cpu_isa_pkg.sv
hdl/board_io_pkg.sv
hdl/instr_fetch.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/cpu_on_board.sv
dv/tb_clock_gen.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV64 board core testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
